//--- flist.f
hw/fpu_pkg.sv
hw/fp_addsub.sv
hw/fp_mul.sv
hw/fp_sign_cmp.sv
hw/fpu.sv
testbench/fpu_checker.sv
testbench/fpu_tb.sv

//--- hw/fp_addsub.sv
`timescale 1ns/1ns
`default_nettype none

module fp_addsub
    import fpu_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  sub,
    input  fp32_t a,
    input  fp32_t b,
    output fp32_t sum
);

    logic              a_zero;
    logic              b_zero;
    logic              b_sign;
    logic [30:0]       a_key;
    logic [30:0]       b_key;
    logic              a_big;
    logic [23:0]       a_m;
    logic [23:0]       b_m;
    logic              big_sign;
    logic              small_sign;
    logic [7:0]        big_exp;
    logic [7:0]        small_exp;
    logic [7:0]        shamt;
    logic [26:0]       big_man;
    logic [26:0]       small_man;
    logic [26:0]       small_aln;
    logic [27:0]       raw;
    logic [4:0]        lz;
    logic [26:0]       norm;
    logic signed [9:0] exp_res;
    logic [22:0]       man_res;
    fp32_t             res;

    // Leading zeros of the 27-bit magnitude
    function automatic logic [4:0] lzc27(input logic [26:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd0;
        found = 1'b0;
        for (int i = 26; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 5'd1;
                end
            end
        end
        return n;
    endfunction

    if (ADDSUB_LAT != 1) begin : g_lat_err
        $error("fp_addsub has exactly one register stage");
    end

    always_comb begin
        a_zero = (a.exp == 8'd0);
        b_zero = (b.exp == 8'd0);
        b_sign = b.sign ^ sub;
        a_key  = a_zero ? 31'd0 : {a.exp, a.man};
        b_key  = b_zero ? 31'd0 : {b.exp, b.man};
        a_m    = a_zero ? 24'd0 : {1'b1, a.man}; // Hidden bit
        b_m    = b_zero ? 24'd0 : {1'b1, b.man};
        a_big  = (a_key >= b_key);

        big_sign   = a_big ? a.sign : b_sign;
        small_sign = a_big ? b_sign : a.sign;
        big_exp    = a_big ? a.exp : b.exp;
        small_exp  = a_big ? b.exp : a.exp;
        big_man    = {a_big ? a_m : b_m, 3'b000};  // Three guard bits
        small_man  = {a_big ? b_m : a_m, 3'b000};

        shamt     = big_exp - small_exp;
        small_aln = small_man >> shamt;            // No sticky bit

        if (big_sign == small_sign) begin
            raw = {1'b0, big_man} + {1'b0, small_aln};
        end else begin
            raw = {1'b0, big_man} - {1'b0, small_aln};
        end

        lz   = lzc27(raw[26:0]);
        norm = raw[26:0] << lz;

        if (raw[27]) begin
            exp_res = $signed({2'b00, big_exp}) + 10'sd1;
            man_res = raw[26:4];
        end else begin
            exp_res = $signed({2'b00, big_exp}) - $signed({5'b00000, lz});
            man_res = norm[25:3];
        end

        if (raw == 28'd0) begin
            // Cancellation gives +0, two zeros keep their sign
            res = '{sign: (big_sign == small_sign) ? big_sign : 1'b0, exp: 8'd0, man: 23'd0};
        end else if (exp_res >= 10'sd255) begin
            res = '{sign: big_sign, exp: 8'hff, man: 23'd0};
        end else if (exp_res <= 10'sd0) begin
            res = '{sign: big_sign, exp: 8'd0, man: 23'd0};
        end else begin
            res = '{sign: big_sign, exp: exp_res[7:0], man: man_res};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sum <= '0;
        end else begin
            sum <= res;
        end
    end

endmodule

`default_nettype wire

//--- hw/fp_mul.sv
`timescale 1ns/1ns
`default_nettype none

module fp_mul
    import fpu_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  fp32_t a,
    input  fp32_t b,
    output fp32_t prod
);

    logic              s1_zero;
    logic              s1_sign;
    logic signed [9:0] s1_exp;
    logic [47:0]       s1_prod;
    logic signed [9:0] exp_sum;
    logic signed [9:0] exp_res;
    logic [22:0]       man_res;
    fp32_t             res;

    if (MUL_LAT != 2) begin : g_lat_err
        $error("fp_mul has exactly two register stages");
    end

    assign exp_sum = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp})
                   - $signed(10'(EXP_BIAS));

    // Stage 1
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_zero <= 1'b1;
            s1_sign <= 1'b0;
        end else begin
            s1_zero <= (a.exp == 8'd0) || (b.exp == 8'd0);
            s1_sign <= a.sign ^ b.sign;
        end
    end

    always_ff @(posedge clk) begin
        s1_exp  <= exp_sum;
        s1_prod <= {1'b1, a.man} * {1'b1, b.man};
    end

    // Product is in [1,4), at most one bit of normalization
    always_comb begin
        if (s1_prod[47]) begin
            exp_res = s1_exp + 10'sd1;
            man_res = s1_prod[46:24];
        end else begin
            exp_res = s1_exp;
            man_res = s1_prod[45:23];
        end

        if (s1_zero) begin
            res = '{sign: s1_sign, exp: 8'd0, man: 23'd0};
        end else if (exp_res >= 10'sd255) begin
            res = '{sign: s1_sign, exp: 8'hff, man: 23'd0}; // Overflow to inf
        end else if (exp_res <= 10'sd0) begin
            res = '{sign: s1_sign, exp: 8'd0, man: 23'd0};  // Flush
        end else begin
            res = '{sign: s1_sign, exp: exp_res[7:0], man: man_res};
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        if (!rstn) begin
            prod <= '0;
        end else begin
            prod <= res;
        end
    end

endmodule

`default_nettype wire

//--- hw/fp_sign_cmp.sv
`timescale 1ns/1ns
`default_nettype none

module fp_sign_cmp
    import fpu_pkg::*;
(
    input  fp32_t a,
    input  fp32_t b,
    output fp32_t half,
    output fp32_t abs,
    output fp32_t neg,
    output logic  eq,
    output logic  le
);

    logic        a_zero;
    logic        b_zero;
    logic [30:0] a_key;
    logic [30:0] b_key;

    assign a_zero = (a.exp == 8'd0);
    assign b_zero = (b.exp == 8'd0);
    assign a_key  = a_zero ? 31'd0 : {a.exp, a.man};
    assign b_key  = b_zero ? 31'd0 : {b.exp, b.man};

    always_comb begin
        if (a.exp <= 8'd1) begin
            half = '{sign: a.sign, exp: 8'd0, man: 23'd0}; // Underflows to zero
        end else begin
            half = '{sign: a.sign, exp: a.exp - 8'd1, man: a.man};
        end
        abs = '{sign: 1'b0, exp: a.exp, man: a_zero ? 23'd0 : a.man};
        neg = '{sign: ~a.sign, exp: a.exp, man: a_zero ? 23'd0 : a.man};
    end

    always_comb begin
        // +0 and -0 compare equal
        eq = (a_key == b_key) && ((a_key == 31'd0) || (a.sign == b.sign));

        if (a_zero && b_zero) begin
            le = 1'b1;
        end else if (a.sign != b.sign) begin
            le = a.sign;
        end else if (a.sign) begin
            le = (a_key >= b_key);  // Both negative
        end else begin
            le = (a_key <= b_key);
        end
    end

endmodule

`default_nettype wire

//--- hw/fpu.sv
`timescale 1ns/1ns
`default_nettype none

module fpu
    import fpu_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        en,
    input  logic [3:0]  ctl,
    input  logic [31:0] x1,
    input  logic [31:0] x2,
    output logic        ready,
    output logic [31:0] y
);

    fpu_req_t    req;
    fpu_op_e     op_in;
    logic        op_ok;
    logic [1:0]  lat_in;
    logic        busy;
    logic [1:0]  cnt;
    logic        accept;
    logic        sub;
    fp32_t       sum;
    fp32_t       prod;
    fp32_t       half;
    fp32_t       abs_v;
    fp32_t       neg_v;
    logic        eq;
    logic        le;
    logic [31:0] res;

    assign op_in  = fpu_op_e'(ctl);
    assign accept = en && op_ok && !busy;
    assign sub    = (req.op == OP_SUB);

    // Latency of the requested op, unknown codes are dropped
    always_comb begin
        op_ok  = 1'b1;
        lat_in = 2'd0;
        case (op_in)
            OP_ADD, OP_SUB: lat_in = 2'(ADDSUB_LAT);
            OP_MUL:         lat_in = 2'(MUL_LAT);
            OP_HALF, OP_EQ, OP_LE, OP_ABS, OP_NEG: lat_in = 2'd0;
            default:        op_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= '{op: op_in, a: x1, b: x2};
        end
    end

    fp_addsub addsub_inst (
        .clk  (clk),
        .rstn (rstn),
        .sub  (sub),
        .a    (req.a),
        .b    (req.b),
        .sum  (sum)
    );

    fp_mul mul_inst (
        .clk  (clk),
        .rstn (rstn),
        .a    (req.a),
        .b    (req.b),
        .prod (prod)
    );

    fp_sign_cmp sign_cmp_inst (
        .a    (req.a),
        .b    (req.b),
        .half (half),
        .abs  (abs_v),
        .neg  (neg_v),
        .eq   (eq),
        .le   (le)
    );

    always_comb begin
        case (req.op)
            OP_ADD, OP_SUB: res = sum;
            OP_MUL:         res = prod;
            OP_HALF:        res = half;
            OP_EQ:          res = {31'd0, eq}; // Compare result in bit 0
            OP_LE:          res = {31'd0, le};
            OP_ABS:         res = abs_v;
            OP_NEG:         res = neg_v;
            default:        res = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ready <= 1'b0;
            y     <= 32'd0;
            busy  <= 1'b0;
            cnt   <= 2'd0;
        end else begin
            ready <= 1'b0;
            if (!busy) begin
                if (accept) begin
                    busy <= 1'b1;
                    cnt  <= lat_in;
                end
            end else if (cnt != 2'd0) begin
                cnt <= cnt - 2'd1;     // Unit still in flight
            end else begin
                busy  <= 1'b0;
                ready <= 1'b1;
                y     <= res;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

    // Register stages inside the pipelined units
    localparam int ADDSUB_LAT = 1;
    localparam int MUL_LAT    = 2;

    localparam int EXP_BIAS   = 127;

    // IEEE-754 single precision layout
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [22:0] man;
    } fp32_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MUL  = 4'd2,
        OP_HALF = 4'd5,
        OP_EQ   = 4'd9,
        OP_LE   = 4'd10,
        OP_ABS  = 4'd11,
        OP_NEG  = 4'd12
    } fpu_op_e;

    typedef struct packed {
        fpu_op_e op;
        fp32_t   a;
        fp32_t   b;
    } fpu_req_t;

endpackage

`default_nettype wire

//--- testbench/fpu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_checker
    import fpu_pkg::*;
(
    input logic       clk,
    input logic       rstn,
    input logic       accept,
    input logic [3:0] op,
    input logic       ready
);

    logic short_op;
    logic addsub_op;
    logic mul_op;

    assign short_op  = (op == OP_HALF) || (op == OP_EQ) || (op == OP_LE) ||
                       (op == OP_ABS) || (op == OP_NEG);
    assign addsub_op = (op == OP_ADD) || (op == OP_SUB);
    assign mul_op    = (op == OP_MUL);

    ready_pulse: assert property (@(posedge clk) disable iff (!rstn) ready |=> !ready)
        else $error("ready high for more than one cycle");

    ready_reset: assert property (@(posedge clk) !rstn |=> !ready)
        else $error("ready not low after a reset cycle");

    // Sampled ready trails the edge that sets it by one clock
    short_lat: assert property (@(posedge clk) disable iff (!rstn)
        accept && short_op |=> !ready ##1 ready)
        else $error("sign or compare op did not finish after one cycle");

    addsub_lat: assert property (@(posedge clk) disable iff (!rstn)
        accept && addsub_op |=> !ready [*2] ##1 ready)
        else $error("add or sub did not finish after two cycles");

    mul_lat: assert property (@(posedge clk) disable iff (!rstn)
        accept && mul_op |=> !ready [*3] ##1 ready)
        else $error("mul did not finish after three cycles");

endmodule

`default_nettype wire

//--- testbench/fpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_tb
    import fpu_pkg::*;
();

    typedef struct packed {
        logic [31:0] y;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  op;
        logic [1:0]  lat;
        logic [31:0] cyc;
    } expect_t;

    logic        clk = 1'b0;
    logic        rstn;
    logic        en;
    logic [3:0]  ctl;
    logic [31:0] x1;
    logic [31:0] x2;
    logic        ready;
    logic [31:0] y;
    logic        ready_q;

    expect_t     pending[$];
    int          cycle      = 0;
    int          lat_budget = 0;
    int          checks     = 0;
    int          errors     = 0;

    always #10 clk = ~clk;

    fpu fpu_inst (
        .clk   (clk),
        .rstn  (rstn),
        .en    (en),
        .ctl   (ctl),
        .x1    (x1),
        .x2    (x2),
        .ready (ready),
        .y     (y)
    );

    bind fpu fpu_checker checker_inst (
        .clk    (clk),
        .rstn   (rstn),
        .accept (accept),
        .op     (ctl),
        .ready  (ready)
    );

    // Cycles from the sampling edge of en to the ready pulse, 0 for dropped codes
    function automatic int op_latency(input logic [3:0] op);
        case (op)
            OP_ADD, OP_SUB: return 2;
            OP_MUL:         return 3;
            OP_HALF, OP_EQ, OP_LE, OP_ABS, OP_NEG: return 1;
            default:        return 0;
        endcase
    endfunction

    function automatic logic [31:0] add_truncated(input fp32_t p, input fp32_t q);
        fp32_t           t;
        longint unsigned mp;
        longint unsigned mq;
        longint unsigned mag;
        int              e;
        if (p.exp == 8'd0 && q.exp == 8'd0) begin
            return {(p.sign == q.sign) ? p.sign : 1'b0, 31'd0};
        end
        if (q.exp != 8'd0 && (p.exp == 8'd0 || {q.exp, q.man} > {p.exp, p.man})) begin
            t = p;      // Larger magnitude goes first
            p = q;
            q = t;
        end
        mp = {40'd0, 1'b1, p.man} << 3;
        mq = (q.exp == 8'd0) ? 64'd0 : ({40'd0, 1'b1, q.man} << 3) >> (p.exp - q.exp);
        mag = (p.sign == q.sign) ? mp + mq : mp - mq;
        if (mag == 64'd0) begin
            return 32'd0;
        end
        e = p.exp;
        if (mag >= (64'd1 << 27)) begin
            mag = mag >> 1; // Carry out
            e   = e + 1;
        end
        while (mag < (64'd1 << 26)) begin
            mag = mag << 1;
            e   = e - 1;
        end
        if (e >= 255) begin
            return {p.sign, 8'hff, 23'd0};
        end
        if (e <= 0) begin
            return {p.sign, 31'd0};
        end
        return {p.sign, e[7:0], mag[25:3]};
    endfunction

    function automatic logic [31:0] mul_truncated(input fp32_t p, input fp32_t q);
        logic            sr;
        longint unsigned prod;
        int              e;
        sr = p.sign ^ q.sign;
        if (p.exp == 8'd0 || q.exp == 8'd0) begin
            return {sr, 31'd0};
        end
        prod = {40'd0, 1'b1, p.man} * {40'd0, 1'b1, q.man};
        e    = int'(p.exp) + int'(q.exp) - EXP_BIAS;
        if (prod >= (64'd1 << 47)) begin
            prod = prod >> 1;
            e    = e + 1;
        end
        if (e >= 255) begin
            return {sr, 8'hff, 23'd0};
        end
        if (e <= 0) begin
            return {sr, 31'd0};
        end
        return {sr, e[7:0], prod[45:23]};
    endfunction

    // Signed magnitude as one number, both zeros map to 0
    function automatic longint order_key(input fp32_t v);
        longint mag;
        mag = (v.exp == 8'd0) ? 64'sd0 : longint'({v.exp, v.man});
        return v.sign ? -mag : mag;
    endfunction

    function automatic logic [31:0] ref_fpu(input logic [3:0] op, input fp32_t a,
                                            input fp32_t b);
        fp32_t nb;
        nb      = b;
        nb.sign = ~b.sign;
        case (op)
            OP_ADD:  return add_truncated(a, b);
            OP_SUB:  return add_truncated(a, nb);
            OP_MUL:  return mul_truncated(a, b);
            OP_HALF: return (a.exp <= 8'd1) ? {a.sign, 31'd0} : {a.sign, a.exp - 8'd1, a.man};
            OP_ABS:  return {1'b0, a.exp, (a.exp == 8'd0) ? 23'd0 : a.man};
            OP_NEG:  return {~a.sign, a.exp, (a.exp == 8'd0) ? 23'd0 : a.man};
            OP_EQ:   return {31'd0, order_key(a) == order_key(b)};
            OP_LE:   return {31'd0, order_key(a) <= order_key(b)};
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] rand_operand(input int mode);
        fp32_t v;
        v.sign = $urandom_range(1, 0);
        v.man  = $urandom;
        case (mode)
            0:       v.exp = $urandom_range(254, 1);
            1:       v.exp = $urandom_range(40, 1);    // Products underflow
            2:       v.exp = $urandom_range(254, 200); // Products overflow
            default: v.exp = $urandom_range(140, 115); // Close exponents
        endcase
        return v;
    endfunction

    function automatic logic [3:0] rand_op();
        case ($urandom_range(7, 0))
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_MUL;
            3:       return OP_HALF;
            4:       return OP_EQ;
            5:       return OP_LE;
            6:       return OP_ABS;
            default: return OP_NEG;
        endcase
    endfunction

    task automatic drive(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        #2;
        en  = 1'b1;
        ctl = op;
        x1  = a;
        x2  = b;
    endtask

    task automatic expect_result(input logic [3:0] op, input logic [31:0] a,
                                 input logic [31:0] b);
        expect_t e;
        e.y   = ref_fpu(op, a, b);
        e.a   = a;
        e.b   = b;
        e.op  = op;
        e.lat = 2'(op_latency(op));
        e.cyc = cycle;
        pending.push_back(e);
        lat_budget += op_latency(op);
    endtask

    task automatic release_en();
        @(posedge clk);
        #2;
        en = 1'b0;
    endtask

    task automatic wait_done();
        while (pending.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic run(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
        drive(op, a, b);
        if (op_latency(op) != 0) begin
            expect_result(op, a, b);
        end else begin
            lat_budget += 1;
        end
        release_en();
        wait_done();
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > 4 * lat_budget + 200) begin
            $display("Timeout after %0d cycles, %0d results never arrived", cycle,
                     pending.size());
            $display("Regression failed");
            $finish;
        end
    end

    always @(negedge clk) begin : compare_proc
        expect_t e;
        int      got_lat;
        if (rstn) begin
            if (ready && ready_q) begin
                errors++;
                $display("ready stayed high for a second cycle at %0t", $time);
            end
            if (ready && !ready_q) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("ready raised at %0t with no request outstanding", $time);
                end else begin
                    e       = pending.pop_front();
                    got_lat = cycle - int'(e.cyc) - 1;
                    checks++;
                    if (y !== e.y) begin
                        errors++;
                        $display("ERR %0t y: expected %h got %h (op %0d, x1 %h, x2 %h)",
                                 $time, e.y, y, e.op, e.a, e.b);
                    end
                    if (got_lat != int'(e.lat)) begin
                        errors++;
                        $display("ready came %0d cycles after en instead of %0d (op %0d) at %0t",
                                 got_lat, e.lat, e.op, $time);
                    end
                end
            end
        end
        ready_q = ready;
    end

    initial begin : main_proc
        logic [31:0] a;
        logic [31:0] b;
        int          mode;
        void'($urandom(32'h1a376998));
        rstn = 1'b0;
        en   = 1'b0;
        ctl  = 4'd0;
        x1   = 32'd0;
        x2   = 32'd0;
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        checks++;
        if (ready !== 1'b0) begin
            errors++;
            $display("ERR %0t ready: expected 0 got %b", $time, ready);
        end
        if (y !== 32'd0) begin
            errors++;
            $display("ERR %0t y: expected %h got %h", $time, 32'd0, y);
        end

        run(OP_ADD, 32'h3f800000, 32'h3f800000);
        run(OP_ADD, 32'h3fc00000, 32'h40100000);
        run(OP_ADD, 32'h3f800000, 32'hbf800000);    // Cancels to +0
        run(OP_SUB, 32'h40200000, 32'h40200000);
        run(OP_ADD, 32'h80000000, 32'h80000000);
        run(OP_ADD, 32'h00000000, 32'h80000000);
        run(OP_ADD, 32'h00400000, 32'h40400000);    // Denormal read as zero
        run(OP_ADD, 32'h7f7fffff, 32'h7f7fffff);    // Overflow
        run(OP_SUB, 32'h00800000, 32'h00800001);    // Underflow
        run(OP_SUB, 32'h3f800000, 32'h3f800001);
        run(OP_MUL, 32'h40000000, 32'h40400000);
        run(OP_MUL, 32'h3fc00000, 32'hbfc00000);
        run(OP_MUL, 32'h00800000, 32'h3f000000);    // Flush
        run(OP_MUL, 32'h7f000000, 32'h7f000000);
        run(OP_MUL, 32'h80000000, 32'h40000000);
        run(OP_MUL, 32'h3f800001, 32'h3f800001);
        run(OP_HALF, 32'h40000000, 32'h0);
        run(OP_HALF, 32'h00800000, 32'h0);          // Exponent 1
        run(OP_HALF, 32'h80ffffff, 32'h0);
        run(OP_ABS, 32'hc0400000, 32'h0);
        run(OP_ABS, 32'h80123456, 32'h0);
        run(OP_NEG, 32'h00000000, 32'h0);
        run(OP_EQ, 32'h00000000, 32'h80000000);
        run(OP_EQ, 32'h3f800000, 32'hbf800000);
        run(OP_EQ, 32'h00400000, 32'h00000000);
        run(OP_LE, 32'hc0000000, 32'hbf800000);
        run(OP_LE, 32'hbf800000, 32'hc0000000);
        run(OP_LE, 32'h80000000, 32'h00000000);
        run(OP_LE, 32'h00000000, 32'h80000000);
        run(OP_LE, 32'h40000000, 32'h3f800000);
        run(OP_LE, 32'h00000000, 32'hbf800000);

        // Requests during a busy period are dropped
        drive(OP_MUL, 32'h40400000, 32'h40a00000);
        expect_result(OP_MUL, 32'h40400000, 32'h40a00000);
        drive(OP_ADD, 32'h3f800000, 32'h3f800000);
        drive(OP_NEG, 32'h3f800000, 32'h0);
        drive(OP_EQ, 32'h0, 32'h0);
        lat_budget += 3;
        drive(OP_HALF, 32'h41000000, 32'h0);   // Accepted once the mul is done
        expect_result(OP_HALF, 32'h41000000, 32'h0);
        drive(OP_ABS, 32'hc1000000, 32'h0);
        lat_budget += 1;
        release_en();
        wait_done();

        for (int code = 0; code < 16; code++) begin
            if (op_latency(4'(code)) == 0) begin
                run(4'(code), 32'h3f800000, 32'h40000000);
            end
        end
        repeat (4) @(posedge clk);

        for (int i = 0; i < 400; i++) begin
            mode = $urandom_range(3, 0);
            a    = rand_operand(mode);
            b    = rand_operand(mode);
            if ($urandom_range(7, 0) == 0) begin
                b = ($urandom_range(1, 0) != 0) ? a : {~a[31], a[30:0]};
            end
            run(rand_op(), a, b);
        end

        repeat (6) @(posedge clk);
        $display("Results checked: %0d  errors: %0d  still outstanding: %0d", checks, errors,
                 pending.size());
        if (errors == 0 && pending.size() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
